//--- logic/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// fetch address and block geometry
`define FE_ADDR_W       32
`define FE_BLOCK_W      5
`define FE_BLOCK_BYTES  (1 << `FE_BLOCK_W)

// target buffer, direct mapped
`define FE_BTB_IDX_W    6
`define FE_BTB_DEPTH    (1 << `FE_BTB_IDX_W)
`define FE_TAG_W        (`FE_ADDR_W - `FE_BTB_IDX_W - `FE_BLOCK_W)

// pattern tables
`define FE_PHT_IDX_W    10
`define FE_PHT_DEPTH    (1 << `FE_PHT_IDX_W)

// global history, and the slice of it each table hashes in
`define FE_GHIST_W      10
`define FE_HIST_LEN0    2
`define FE_HIST_LEN1    6
`define FE_HIST_LEN2    10

`define FE_RAS_DEPTH    8

`define FE_RESET_IP     32'h0000_1000

`endif

//--- logic/fe_pkg.sv
`include "fe_consts.svh"

package fe_pkg;

  typedef logic [`FE_ADDR_W-1:0]  addr_t;
  typedef logic [`FE_GHIST_W-1:0] ghist_t;  // bit 0 is the newest outcome
  typedef logic [`FE_TAG_W-1:0]   tag_t;
  typedef logic [1:0]             ctr_t;

  typedef enum logic [1:0] {
    br_cond = 2'd0,
    br_jump = 2'd1,
    br_call = 2'd2,
    br_ret  = 2'd3
  } br_kind_t;

  // 1 + 21 + 2 + 32 = 56 bits
  typedef struct packed {
    logic     valid;
    tag_t     tag;     // address bits 31..11
    br_kind_t kind;
    addr_t    target;
  } btb_entry_t;

  localparam ctr_t CTR_WEAK_NT = 2'b01;

endpackage

//--- logic/fe_ifs.sv
`timescale 1ns/10ps

// lookup side, one fetch block per cycle
interface fe_lookup_if;
  import fe_pkg::*;

  addr_t      ip;
  ghist_t     ghist;
  logic       btb_hit;
  btb_entry_t btb_entry;
  logic       pred_taken;
  addr_t      ras_top;
  logic       push;
  logic       pop;
  logic       advance;

  modport ctrl (
    output ip, ghist, push, pop, advance,
    input  btb_hit, btb_entry, pred_taken, ras_top
  );

  modport btb (
    input  ip,
    output btb_hit, btb_entry
  );

  modport pht (
    input  ip, ghist,
    output pred_taken
  );

  modport ras (
    input  ip, push, pop, advance,
    output ras_top
  );
endinterface

// resolved branch, a single-cycle pulse
interface fe_resolve_if;
  import fe_pkg::*;

  logic     valid;
  addr_t    ip;
  br_kind_t kind;
  logic     taken;
  addr_t    target;
  ghist_t   ghist;  // history the branch was predicted with
  logic     mispredict;

  modport source (output valid, ip, kind, taken, target, ghist, mispredict);
  modport sink   (input  valid, ip, kind, taken, target, ghist, mispredict);
endinterface

//--- logic/lookup_table.sv
`timescale 1ns/10ps

module lookup_table #(
  parameter type    entry_t   = logic [7:0],
  parameter int     DEPTH     = 16,
  parameter entry_t RESET_VAL = '0,
  parameter int     RD_PORTS  = 1,
  localparam int    IDX_W     = $clog2(DEPTH)
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [RD_PORTS-1:0][IDX_W-1:0] rd_idx,
  output entry_t [RD_PORTS-1:0]         rd_data,
  input  logic                          wr_en,
  input  logic [IDX_W-1:0]              wr_idx,
  input  entry_t                        wr_data
);

  entry_t mem [DEPTH];

  // reads see the old entry when written in the same cycle
  for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd
    assign rd_data[p] = mem[rd_idx[p]];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= RESET_VAL;
      end
    end else if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  a_wr_en_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(wr_en));

endmodule

//--- logic/target_buffer.sv
`timescale 1ns/10ps
`include "fe_consts.svh"

module target_buffer (
  input logic        clk,
  input logic        rst,
  fe_lookup_if.btb   lk,
  fe_resolve_if.sink rs
);
  import fe_pkg::*;

  typedef logic [`FE_BTB_IDX_W-1:0] btb_idx_t;

  btb_idx_t         rd_idx;
  btb_idx_t         wr_idx;
  tag_t             rd_tag;
  btb_entry_t [0:0] rd_entry;
  btb_entry_t       wr_entry;
  logic             wr_en;

  assign rd_idx = lk.ip[`FE_BLOCK_W +: `FE_BTB_IDX_W];  // ip[10:5]
  assign rd_tag = lk.ip[`FE_ADDR_W-1 -: `FE_TAG_W];     // ip[31:11]

  assign lk.btb_entry = rd_entry[0];
  assign lk.btb_hit   = rd_entry[0].valid && (rd_entry[0].tag == rd_tag);

  // only taken branches are worth an entry
  assign wr_en  = rs.valid && rs.taken;
  assign wr_idx = rs.ip[`FE_BLOCK_W +: `FE_BTB_IDX_W];

  always_comb begin
    wr_entry.valid  = 1'b1;
    wr_entry.tag    = rs.ip[`FE_ADDR_W-1 -: `FE_TAG_W];
    wr_entry.kind   = rs.kind;
    wr_entry.target = rs.target;
  end

  lookup_table #(
    .entry_t   (btb_entry_t),
    .DEPTH     (`FE_BTB_DEPTH),
    .RESET_VAL ('0)
  ) u_table (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (rd_idx),
    .rd_data (rd_entry),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_entry)
  );

endmodule

//--- logic/hashed_predictor.sv
`timescale 1ns/10ps
`include "fe_consts.svh"

module hashed_predictor (
  input logic        clk,
  input logic        rst,
  fe_lookup_if.pht   lk,
  fe_resolve_if.sink rs
);
  import fe_pkg::*;

  typedef logic [`FE_PHT_IDX_W-1:0] pht_idx_t;

  localparam int NUM_TBL = 3;
  localparam int HIST_LEN [NUM_TBL] = '{`FE_HIST_LEN0, `FE_HIST_LEN1, `FE_HIST_LEN2};

  logic [NUM_TBL-1:0] vote;
  logic               train;

  // block address bits 14..5 xor the newest len history bits
  function automatic pht_idx_t pht_index(addr_t addr, ghist_t hist, int len);
    ghist_t masked;
    masked = hist & ~(ghist_t'('1) << len);
    return addr[`FE_BLOCK_W +: `FE_PHT_IDX_W] ^ pht_idx_t'(masked);
  endfunction

  function automatic ctr_t ctr_step(ctr_t cur, logic taken);
    if (taken) begin
      return (cur == 2'b11) ? cur : ctr_t'(cur + 2'd1);
    end
    return (cur == 2'b00) ? cur : ctr_t'(cur - 2'd1);
  endfunction

  assign train = rs.valid && (rs.kind == br_cond);  // hold does not matter here

  for (genvar g = 0; g < NUM_TBL; g++) begin : g_tbl
    pht_idx_t   lk_idx;
    pht_idx_t   up_idx;
    ctr_t [1:0] ctr;    // [0] lookup, [1] resolve
    ctr_t       ctr_nxt;

    assign lk_idx  = pht_index(lk.ip, lk.ghist, HIST_LEN[g]);
    assign up_idx  = pht_index(rs.ip, rs.ghist, HIST_LEN[g]);
    assign ctr_nxt = ctr_step(ctr[1], rs.taken);
    assign vote[g] = ctr[0][1];

    lookup_table #(
      .entry_t   (ctr_t),
      .DEPTH     (`FE_PHT_DEPTH),
      .RESET_VAL (CTR_WEAK_NT),
      .RD_PORTS  (2)
    ) u_table (
      .clk     (clk),
      .rst     (rst),
      .rd_idx  ({up_idx, lk_idx}),
      .rd_data (ctr),
      .wr_en   (train),
      .wr_idx  (up_idx),
      .wr_data (ctr_nxt)
    );
  end

  // majority of the three upper bits
  assign lk.pred_taken = (vote[0] & vote[1]) | (vote[0] & vote[2]) | (vote[1] & vote[2]);

endmodule

//--- logic/return_stack.sv
`timescale 1ns/10ps
`include "fe_consts.svh"

module return_stack (
  input logic      clk,
  input logic      rst,
  fe_lookup_if.ras lk
);
  import fe_pkg::*;

  localparam int PTR_W = $clog2(`FE_RAS_DEPTH);
  localparam int CNT_W = $clog2(`FE_RAS_DEPTH + 1);

  addr_t            stack [`FE_RAS_DEPTH];
  logic [PTR_W-1:0] top_ptr;
  logic [PTR_W-1:0] push_ptr;
  logic [CNT_W-1:0] depth_cnt;  // saturates while the pointer wraps

  assign push_ptr   = top_ptr + 1'b1;
  assign lk.ras_top = (depth_cnt == '0) ? '0 : stack[top_ptr];

  // return address is the block after the call
  always_ff @(posedge clk) begin
    if (lk.push) begin
      stack[push_ptr] <= addr_t'(lk.ip + `FE_BLOCK_BYTES);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      top_ptr   <= '0;
      depth_cnt <= '0;
    end else if (lk.push) begin
      top_ptr <= push_ptr;
      if (depth_cnt != CNT_W'(`FE_RAS_DEPTH)) begin
        depth_cnt <= depth_cnt + 1'b1;
      end
    end else if (lk.pop && depth_cnt != '0) begin  // pop on empty is ignored
      top_ptr   <= top_ptr - 1'b1;
      depth_cnt <= depth_cnt - 1'b1;
    end
  end

  a_push_pop_excl: assert property (@(posedge clk) disable iff (rst) !(lk.push && lk.pop));

endmodule

//--- logic/fetch_pc_ctrl.sv
`timescale 1ns/10ps
`include "fe_consts.svh"

module fetch_pc_ctrl (
  input  logic           clk,
  input  logic           rst,
  input  logic           fetch_hold,
  fe_lookup_if.ctrl      lk,
  fe_resolve_if.sink     rs,
  output fe_pkg::addr_t  fetch_ip,
  output fe_pkg::ghist_t fetch_ghist,
  output logic           fetch_valid
);
  import fe_pkg::*;

  addr_t  ip_q;
  addr_t  seq_ip;
  addr_t  next_ip;
  addr_t  redir_ip;
  ghist_t ghist_q;
  ghist_t next_ghist;
  ghist_t redir_ghist;
  logic   valid_q;
  logic   redirect;

  function automatic addr_t blk_align(addr_t addr);
    return {addr[`FE_ADDR_W-1:`FE_BLOCK_W], {`FE_BLOCK_W{1'b0}}};
  endfunction

  assign redirect = rs.valid && rs.mispredict;

  // the presented block is consumed
  assign lk.advance = valid_q && !fetch_hold && !redirect;
  assign lk.ip      = ip_q;
  assign lk.ghist   = ghist_q;

  assign seq_ip = addr_t'(ip_q + `FE_BLOCK_BYTES);

  always_comb begin
    next_ip    = seq_ip;
    next_ghist = ghist_q;
    lk.push    = 1'b0;
    lk.pop     = 1'b0;
    if (lk.btb_hit) begin
      unique case (lk.btb_entry.kind)
        br_jump: next_ip = blk_align(lk.btb_entry.target);
        br_call: begin
          next_ip = blk_align(lk.btb_entry.target);
          lk.push = lk.advance;
        end
        br_ret: begin
          next_ip = lk.ras_top;
          lk.pop  = lk.advance;
        end
        br_cond: begin
          if (lk.pred_taken) begin
            next_ip = blk_align(lk.btb_entry.target);
          end
          next_ghist = {ghist_q[`FE_GHIST_W-2:0], lk.pred_taken};
        end
      endcase
    end
  end

  // recovery from the resolved branch
  always_comb begin
    redir_ip = rs.taken ? blk_align(rs.target)
                        : addr_t'(blk_align(rs.ip) + `FE_BLOCK_BYTES);
    if (rs.kind == br_cond) begin
      redir_ghist = {rs.ghist[`FE_GHIST_W-2:0], rs.taken};
    end else begin
      redir_ghist = rs.ghist;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q    <= `FE_RESET_IP;
      ghist_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= !fetch_hold;
      if (redirect) begin      // wins over hold too
        ip_q    <= redir_ip;
        ghist_q <= redir_ghist;
      end else if (lk.advance) begin
        ip_q    <= next_ip;
        ghist_q <= next_ghist;
      end
    end
  end

  assign fetch_ip    = ip_q;
  assign fetch_ghist = ghist_q;
  assign fetch_valid = valid_q;

  a_ip_aligned: assert property (
    @(posedge clk) disable iff (rst) fetch_ip[`FE_BLOCK_W-1:0] == '0
  );

endmodule

//--- logic/fetch_frontend.sv
`timescale 1ns/10ps

module fetch_frontend (
  input  logic             clk,
  input  logic             rst,
  input  logic             fetch_hold,
  input  logic             resolve_valid,
  input  fe_pkg::addr_t    resolve_ip,
  input  fe_pkg::br_kind_t resolve_kind,
  input  logic             resolve_taken,
  input  fe_pkg::addr_t    resolve_target,
  input  fe_pkg::ghist_t   resolve_ghist,
  input  logic             resolve_mispredict,
  output fe_pkg::addr_t    fetch_ip,
  output fe_pkg::ghist_t   fetch_ghist,
  output logic             fetch_valid
);

  fe_lookup_if  lk_if ();
  fe_resolve_if rs_if ();

  assign rs_if.valid      = resolve_valid;
  assign rs_if.ip         = resolve_ip;
  assign rs_if.kind       = resolve_kind;
  assign rs_if.taken      = resolve_taken;
  assign rs_if.target     = resolve_target;
  assign rs_if.ghist      = resolve_ghist;
  assign rs_if.mispredict = resolve_mispredict;

  fetch_pc_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .fetch_hold  (fetch_hold),
    .lk          (lk_if.ctrl),
    .rs          (rs_if.sink),
    .fetch_ip    (fetch_ip),
    .fetch_ghist (fetch_ghist),
    .fetch_valid (fetch_valid)
  );

  target_buffer u_btb (
    .clk (clk),
    .rst (rst),
    .lk  (lk_if.btb),
    .rs  (rs_if.sink)
  );

  hashed_predictor u_pht (
    .clk (clk),
    .rst (rst),
    .lk  (lk_if.pht),
    .rs  (rs_if.sink)
  );

  return_stack u_ras (
    .clk (clk),
    .rst (rst),
    .lk  (lk_if.ras)
  );

endmodule

//--- verification/tb_fetch_frontend.sv
`timescale 1ns/10ps
`include "fe_consts.svh"

module tb_fetch_frontend;
  import fe_pkg::*;

  logic clk, rst, fetch_hold, resolve_valid, resolve_taken, resolve_mispredict;
  addr_t resolve_ip, resolve_target, fetch_ip;
  br_kind_t resolve_kind;
  ghist_t resolve_ghist, fetch_ghist;
  logic fetch_valid;

  fetch_frontend DUT (.*);

  // reference model state
  addr_t m_ip, pool [16], btb_target [64], ras [8];
  ghist_t m_ghist;
  logic m_valid, btb_valid [64];
  logic [20:0] btb_tag [64];
  br_kind_t btb_kind [64];
  logic [1:0] pht [3][1024];
  logic [2:0] ras_ptr;
  int ras_cnt;
  logic [31:0] lfsr_state;
  string test_name;

  always #5 clk = ~clk;

  initial begin
    #1_000_000;
    $display("run did not finish within 1 ms");
    $display("Simulation failed");
    $fatal(1);
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      r[i] = lfsr_state[0];
    end
    return r;
  endfunction

  // block bits 14..5 xor the zero-extended history slice
  function automatic logic [9:0] table_index(input addr_t a, input ghist_t h, input int t);
    ghist_t mask;
    mask = (t == 0) ? 10'h003 : (t == 1) ? 10'h03f : 10'h3ff;
    return a[14:5] ^ (h & mask);
  endfunction

  function automatic logic [1:0] ctr_toward(input logic [1:0] c, input logic taken);
    if (taken && c != 2'b11) return c + 2'd1;
    if (!taken && c != 2'b00) return c - 2'd1;
    return c;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h actual %h", name, exp, act);
      fail_run("value mismatch");
    end
  endtask

  task automatic reset_model();
    m_ip = `FE_RESET_IP;
    m_ghist = '0;
    m_valid = 1'b0;
    ras_ptr = '0;
    ras_cnt = 0;
    for (int i = 0; i < 64; i++) btb_valid[i] = 1'b0;
    for (int t = 0; t < 3; t++)
      for (int i = 0; i < 1024; i++) pht[t][i] = 2'b01;  // weakly not taken
  endtask

  // state after the coming edge, from current state and the driven inputs
  task automatic predict_next();
    logic [5:0] bi, wi;
    logic [9:0] pi;
    logic [2:0] up_ptr;
    logic hit, redirect, advance, push, pop;
    int votes;
    addr_t nip, top;
    ghist_t ngh;
    redirect = resolve_valid && resolve_mispredict;
    advance = m_valid && !fetch_hold && !redirect;
    bi = m_ip[10:5];
    hit = btb_valid[bi] && (btb_tag[bi] == m_ip[31:11]);
    votes = 0;
    for (int t = 0; t < 3; t++) begin
      pi = table_index(m_ip, m_ghist, t);
      if (pht[t][pi][1]) votes++;
    end
    top = (ras_cnt == 0) ? '0 : ras[ras_ptr];
    nip = m_ip + 32;
    ngh = m_ghist;
    push = 1'b0;
    pop = 1'b0;
    if (hit) begin
      case (btb_kind[bi])
        br_jump: nip = {btb_target[bi][31:5], 5'b0};
        br_call: begin
          nip = {btb_target[bi][31:5], 5'b0};
          push = advance;
        end
        br_ret: begin
          nip = top;
          pop = advance;
        end
        default: begin
          if (votes >= 2) nip = {btb_target[bi][31:5], 5'b0};
          ngh = {m_ghist[8:0], votes >= 2};
        end
      endcase
    end
    up_ptr = ras_ptr + 3'd1;
    if (push) begin
      ras[up_ptr] = m_ip + 32;
      ras_ptr = up_ptr;
      if (ras_cnt < 8) ras_cnt++;
    end else if (pop && ras_cnt != 0) begin
      ras_ptr = ras_ptr - 3'd1;
      ras_cnt--;
    end
    if (resolve_valid && resolve_kind == br_cond)
      for (int t = 0; t < 3; t++) begin
        pi = table_index(resolve_ip, resolve_ghist, t);
        pht[t][pi] = ctr_toward(pht[t][pi], resolve_taken);
      end
    if (resolve_valid && resolve_taken) begin
      wi = resolve_ip[10:5];
      btb_valid[wi] = 1'b1;
      btb_tag[wi] = resolve_ip[31:11];
      btb_kind[wi] = resolve_kind;
      btb_target[wi] = resolve_target;
    end
    m_valid = !fetch_hold;
    if (redirect) begin
      m_ip = resolve_taken ? {resolve_target[31:5], 5'b0} : {resolve_ip[31:5], 5'b0} + 32;
      m_ghist = (resolve_kind == br_cond) ? {resolve_ghist[8:0], resolve_taken} : resolve_ghist;
    end else if (advance) begin
      m_ip = nip;
      m_ghist = ngh;
    end
  endtask

  task automatic step_cycle(input logic hold, input logic rv, input addr_t rip,
                            input br_kind_t rkind, input logic rtaken, input addr_t rtgt,
                            input ghist_t rgh, input logic rmisp);
    fetch_hold = hold;
    resolve_valid = rv;
    resolve_ip = rip;
    resolve_kind = rkind;
    resolve_taken = rtaken;
    resolve_target = rtgt;
    resolve_ghist = rgh;
    resolve_mispredict = rmisp;
    predict_next();
    @(posedge clk);
    #1;
    check_value({test_name, " fetch_ip"}, m_ip, fetch_ip);
    check_value({test_name, " fetch_ghist"}, 32'(m_ghist), 32'(fetch_ghist));
    check_value({test_name, " fetch_valid"}, 32'(m_valid), 32'(fetch_valid));
  endtask

  task automatic idle_cycle();
    step_cycle(1'b0, 1'b0, '0, br_cond, 1'b0, '0, '0, 1'b0);
  endtask

  // a not-taken jump mispredict lands on the block after its ip
  task automatic redirect_to(input addr_t a);
    step_cycle(1'b0, 1'b1, a - 32, br_jump, 1'b0, '0, '0, 1'b1);
  endtask

  task automatic wait_for_ip(input addr_t target, input int limit, input string what);
    int n;
    n = 0;
    while (fetch_ip !== target) begin
      if (n == limit) fail_run($sformatf("fetch_ip never reached %h %s", target, what));
      idle_cycle();
      n++;
    end
  endtask

  initial begin
    logic [31:0] r;
    logic hold_r, misp_r;
    addr_t held_ip;
    ghist_t gh_r;
    int n;
    lfsr_state = 32'h14e0_094b;
    clk = 1'b0;
    rst = 1'b1;
    fetch_hold = 1'b0;
    resolve_valid = 1'b0;
    resolve_ip = '0;
    resolve_kind = br_cond;
    resolve_taken = 1'b0;
    resolve_target = '0;
    resolve_ghist = '0;
    resolve_mispredict = 1'b0;
    for (int i = 0; i < 16; i++) pool[i] = `FE_RESET_IP + 32'(i) * 32'h460;
    reset_model();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name = "reset";
    check_value("reset ip", `FE_RESET_IP, fetch_ip);
    check_value("reset ghist", 32'd0, 32'(fetch_ghist));
    n = 0;
    while (!fetch_valid) begin
      if (n == 3) fail_run("fetch_valid did not rise after reset");
      idle_cycle();
      n++;
    end
    held_ip = fetch_ip;
    idle_cycle();
    check_value("sequential block", held_ip + 32, fetch_ip);

    test_name = "jump redirect";
    step_cycle(1'b0, 1'b1, pool[1], br_jump, 1'b1, pool[2], '0, 1'b1);
    redirect_to(pool[1]);
    idle_cycle();
    check_value("jump hit", pool[2], fetch_ip);

    test_name = "cond training";
    repeat (3) step_cycle(1'b0, 1'b1, pool[3], br_cond, 1'b1, pool[6], '0, 1'b0);
    redirect_to(pool[3]);
    idle_cycle();
    check_value("cond taken", pool[6], fetch_ip);
    repeat (3) step_cycle(1'b0, 1'b1, pool[3], br_cond, 1'b0, pool[6], '0, 1'b0);
    redirect_to(pool[3]);
    idle_cycle();
    check_value("cond fall-through", pool[3] + 32, fetch_ip);

    test_name = "call and return";
    step_cycle(1'b0, 1'b1, pool[4], br_call, 1'b1, pool[5], '0, 1'b0);
    step_cycle(1'b0, 1'b1, pool[5], br_ret, 1'b1, pool[0], '0, 1'b0);
    redirect_to(pool[4]);
    wait_for_ip(pool[4] + 32, 4, "after the return");
    // self call nests ten deep, then a ret block drains the stack
    step_cycle(1'b0, 1'b1, pool[8], br_call, 1'b1, pool[8], '0, 1'b0);
    step_cycle(1'b0, 1'b1, pool[8] + 32, br_ret, 1'b1, pool[0], '0, 1'b0);
    redirect_to(pool[8]);
    repeat (10) idle_cycle();
    redirect_to(pool[8] + 32);
    wait_for_ip('0, 12, "while draining the return stack");

    test_name = "fetch hold";
    redirect_to(pool[7]);
    idle_cycle();
    held_ip = fetch_ip;
    repeat (4) begin
      step_cycle(1'b1, 1'b0, '0, br_cond, 1'b0, '0, '0, 1'b0);
      check_value("held ip", held_ip, fetch_ip);
    end
    step_cycle(1'b1, 1'b1, pool[9], br_jump, 1'b1, pool[2], 10'h155, 1'b1);
    check_value("redirect in hold", pool[2], fetch_ip);
    idle_cycle();

    test_name = "random mix";
    for (int c = 0; c < 3000; c++) begin
      r = rand_bits(3);
      hold_r = (r[2:0] == 3'd0);
      r = rand_bits(2);
      misp_r = (r[1:0] == 2'd0);
      r = rand_bits(10);
      gh_r = r[9:0];
      r = rand_bits(1);
      if (r[0]) gh_r = m_ghist;  // often the live history, so lookups train
      r = rand_bits(12);
      step_cycle(hold_r, r[0], pool[r[4:1]], br_kind_t'(r[6:5]), r[7], pool[r[11:8]],
                 gh_r, misp_r);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- build.f
+incdir+logic
logic/fe_pkg.sv
logic/fe_ifs.sv
logic/lookup_table.sv
logic/target_buffer.sv
logic/hashed_predictor.sv
logic/return_stack.sv
logic/fetch_pc_ctrl.sv
logic/fetch_frontend.sv
verification/tb_fetch_frontend.sv

//--- Makefile
TOP := tb_fetch_frontend

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
